// File: logic/mem_settings.svh
// memory subsystem settings
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// bank geometry.
`define MEM_ADDR_W 10               // word address bits.
`define MEM_DATA_W 32               // data word bits.
`define MEM_BE_W   (`MEM_DATA_W/8)  // one enable per byte.

// queueing.
`define FIFO_DEPTH 4                // entries per request and response queue.

// port count on the shared bank.
`define N_PORTS    2                // accelerator-side ports.

`endif

// File: logic/mem_pkg.sv
// memory subsystem types
`include "mem_settings.svh"

package mem_pkg;

  // plain vectors with a meaning.
  typedef logic [`MEM_ADDR_W-1:0] addr_t;  // word address.
  typedef logic [`MEM_DATA_W-1:0] data_t;  // data word.
  typedef logic [`MEM_BE_W-1:0]   be_t;    // byte enables.

  // request payload as it travels from a port to the bank.
  typedef struct packed {
    addr_t addr;   // word address.
    data_t wdata;  // write data.
    be_t   be;     // byte enables for writes.
    logic  wen;    // 1 is a write.
  } mem_req_t;

  // response payload from the bank back to a port.
  typedef struct packed {
    data_t rdata;  // read word, zero for writes.
  } mem_rsp_t;

  // queue status.
  typedef struct packed {
    logic empty;  // nothing stored.
    logic full;   // no room left.
  } fifo_flags_t;

  // last port served by the round robin.
  typedef enum logic [0:0] {
    ARB_LAST_P0 = 1'b0,
    ARB_LAST_P1 = 1'b1
  } arb_state_e;

endpackage

// File: logic/stream_fifo.sv
// synchronous stream FIFO
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 4,
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,       // synchronous flush.
  input  logic                 push_valid_i,
  input  logic [DATA_W-1:0]    push_data_i,
  output logic                 push_ready_o,
  output logic                 pop_valid_o,
  output logic [DATA_W-1:0]    pop_data_o,
  input  logic                 pop_ready_i,
  output mem_pkg::fifo_flags_t flags_o,
  output logic [CNT_W-1:0]     count_o        // current occupancy.
);

  logic [DATA_W-1:0] mem_q [DEPTH];  // circular storage.
  logic [PTR_W-1:0]  wr_ptr_q;        // next slot to write.
  logic [PTR_W-1:0]  rd_ptr_q;        // oldest entry.
  logic [CNT_W-1:0]  count_q;         // entries held.
  logic              push;            // push handshake this cycle.
  logic              pop;             // pop handshake this cycle.

  // wrap at DEPTH so non power of two depths also work.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign push_ready_o  = (count_q != CNT_W'(DEPTH));  // room left.
  assign pop_valid_o   = (count_q != '0);             // data held.
  assign push          = push_valid_i & push_ready_o;
  assign pop           = pop_valid_o & pop_ready_i;
  assign pop_data_o    = mem_q[rd_ptr_q];             // head is always visible.
  assign flags_o.empty = ~pop_valid_o;
  assign flags_o.full  = ~push_ready_o;
  assign count_o       = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // drop all entries.
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);  // fill.
        2'b01:   count_q <= count_q - CNT_W'(1);  // drain.
        default: count_q <= count_q;              // both or neither.
      endcase
    end
  end

  // storage write.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: logic/sram_bank.sv
// single port sram bank
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_bank (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  mem_pkg::mem_req_t req_data_i,
  output logic              rsp_valid_o,
  output mem_pkg::mem_rsp_t rsp_o
);

  localparam int unsigned WORDS = 2 ** `MEM_ADDR_W;

  mem_pkg::data_t mem_q [WORDS];  // word storage.
  mem_pkg::data_t rdata_q;        // registered answer.
  logic           rsp_valid_q;

  // access port with byte merge on writes.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (req_data_i.wen) begin
        for (int b = 0; b < `MEM_BE_W; b++) begin
          if (req_data_i.be[b]) begin
            mem_q[req_data_i.addr][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;                        // writes answer zero.
      end else begin
        rdata_q <= mem_q[req_data_i.addr];    // synchronous read.
      end
    end
  end

  // every access is answered exactly once.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

// File: logic/mem_arbiter.sv
// round robin bank arbiter
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [`N_PORTS-1:0]                 req_i,
  input  mem_pkg::mem_req_t [`N_PORTS-1:0]    req_data_i,
  output logic [`N_PORTS-1:0]                 gnt_o,
  output logic [`N_PORTS-1:0]                 rsp_valid_o,
  output mem_pkg::mem_rsp_t [`N_PORTS-1:0]    rsp_o,
  output logic                                bank_req_o,
  output mem_pkg::mem_req_t                   bank_data_o,
  input  logic                                bank_rsp_valid_i,
  input  mem_pkg::mem_rsp_t                   bank_rsp_i
);

  localparam int unsigned N     = `N_PORTS;
  localparam int unsigned IDX_W = $bits(mem_pkg::arb_state_e);

  mem_pkg::arb_state_e last_q;     // port served most recently.
  logic [IDX_W-1:0]    win_idx;    // port granted this cycle.
  logic                win_valid;  // some port is requesting.
  logic [IDX_W-1:0]    rsp_idx_q;  // owner of next cycle's bank answer.

  // search starts just after the last winner.
  always_comb begin
    int unsigned cand;
    cand      = 0;
    win_valid = 1'b0;
    win_idx   = '0;
    for (int unsigned k = 1; k <= N; k++) begin
      cand = (int'(last_q) + k) % N;
      if (!win_valid && req_i[cand]) begin
        win_valid = 1'b1;          // first requester wins.
        win_idx   = IDX_W'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (win_valid) begin
      gnt_o[win_idx] = 1'b1;  // one hot grant.
    end
  end

  assign bank_req_o  = win_valid;             // bank always accepts.
  assign bank_data_o = req_data_i[win_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q    <= mem_pkg::ARB_LAST_P1;  // port 0 goes first.
      rsp_idx_q <= '0;
    end else if (win_valid) begin
      last_q    <= mem_pkg::arb_state_e'(win_idx);
      rsp_idx_q <= win_idx;               // bank answers one cycle later.
    end
  end

  // response return router.
  for (genvar p = 0; p < `N_PORTS; p++) begin : g_rsp
    assign rsp_valid_o[p] = bank_rsp_valid_i & (rsp_idx_q == IDX_W'(p));
    assign rsp_o[p]       = bank_rsp_i;  // valid alone selects the owner.
  end

endmodule

// File: logic/core_fifo.sv
// port request and response decoupler
`timescale 1ns/1ps
`include "mem_settings.svh"

module core_fifo (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  // port side.
  input  logic                 req_i,
  input  mem_pkg::mem_req_t    req_data_i,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output mem_pkg::mem_rsp_t    r_data_o,
  input  logic                 r_ready_i,
  // arbiter side.
  output logic                 mem_req_o,
  output mem_pkg::mem_req_t    mem_data_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rsp_valid_i,
  input  mem_pkg::mem_rsp_t    mem_rsp_i,
  output mem_pkg::fifo_flags_t flags_o
);

  localparam int unsigned DEPTH = `FIFO_DEPTH;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned REQ_W = $bits(mem_pkg::mem_req_t);
  localparam int unsigned RSP_W = $bits(mem_pkg::mem_rsp_t);

  logic                 req_pop_valid;  // request waiting for the bank.
  logic [REQ_W-1:0]     req_pop_data;
  logic [RSP_W-1:0]     rsp_pop_data;
  logic [CNT_W-1:0]     rsp_count;      // responses waiting for the port.
  logic [CNT_W-1:0]     inflight_q;     // issued but not yet answered.
  logic [CNT_W:0]       reserved;       // slots promised to responses.
  logic                 slot_free;
  logic                 issue;          // request handed to the arbiter.
  mem_pkg::fifo_flags_t req_flags;
  mem_pkg::fifo_flags_t rsp_flags;

  // outgoing request queue, req/gnt become push valid/ready.
  stream_fifo #(
    .DATA_W ( REQ_W ),
    .DEPTH  ( DEPTH )
  ) i_req_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( req_i         ),
    .push_data_i  ( req_data_i    ),
    .push_ready_o ( gnt_o         ),
    .pop_valid_o  ( req_pop_valid ),
    .pop_data_o   ( req_pop_data  ),
    .pop_ready_i  ( issue         ),
    .flags_o      ( req_flags     ),
    .count_o      (               )
  );

  // answers are always accepted since a slot was reserved at issue.
  assign reserved   = {1'b0, inflight_q} + {1'b0, rsp_count};
  assign slot_free  = (reserved < (CNT_W + 1)'(DEPTH));
  assign mem_req_o  = req_pop_valid & slot_free;     // hold back without room.
  assign mem_data_o = mem_pkg::mem_req_t'(req_pop_data);
  assign issue      = mem_req_o & mem_gnt_i;

  // incoming response queue.
  stream_fifo #(
    .DATA_W ( RSP_W ),
    .DEPTH  ( DEPTH )
  ) i_rsp_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( mem_rsp_valid_i ),
    .push_data_i  ( mem_rsp_i       ),
    .push_ready_o (                 ),
    .pop_valid_o  ( r_valid_o       ),
    .pop_data_o   ( rsp_pop_data    ),
    .pop_ready_i  ( r_ready_i       ),
    .flags_o      ( rsp_flags       ),
    .count_o      ( rsp_count       )
  );

  assign r_data_o = mem_pkg::mem_rsp_t'(rsp_pop_data);

  // requests in flight between the grant and the bank answer.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else if (clear_i) begin
      inflight_q <= '0;
    end else if (issue && !mem_rsp_valid_i) begin
      inflight_q <= inflight_q + CNT_W'(1);  // new request out.
    end else if (!issue && mem_rsp_valid_i) begin
      inflight_q <= inflight_q - CNT_W'(1);  // answer came back.
    end
  end

  assign flags_o.empty = req_flags.empty & rsp_flags.empty & (inflight_q == '0);
  assign flags_o.full  = req_flags.full;  // port sees gnt low.

endmodule

// File: logic/mem_subsys_top.sv
// shared memory subsystem top
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsys_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic [`N_PORTS-1:0]                 req_i,
  input  mem_pkg::mem_req_t [`N_PORTS-1:0]    req_data_i,
  output logic [`N_PORTS-1:0]                 gnt_o,
  output logic [`N_PORTS-1:0]                 r_valid_o,
  output mem_pkg::mem_rsp_t [`N_PORTS-1:0]    r_data_o,
  input  logic [`N_PORTS-1:0]                 r_ready_i,
  output mem_pkg::fifo_flags_t                flags_o
);

  logic [`N_PORTS-1:0]                 arb_req;        // queue heads offered.
  mem_pkg::mem_req_t [`N_PORTS-1:0]    arb_data;
  logic [`N_PORTS-1:0]                 arb_gnt;
  logic [`N_PORTS-1:0]                 arb_rsp_valid;  // routed bank answers.
  mem_pkg::mem_rsp_t [`N_PORTS-1:0]    arb_rsp;
  mem_pkg::fifo_flags_t [`N_PORTS-1:0] port_flags;
  logic [`N_PORTS-1:0]                 port_empty;
  logic [`N_PORTS-1:0]                 port_full;
  logic                                bank_req;
  mem_pkg::mem_req_t                   bank_data;
  logic                                bank_rsp_valid;
  mem_pkg::mem_rsp_t                   bank_rsp;

  // one decoupler per port.
  for (genvar p = 0; p < `N_PORTS; p++) begin : g_port
    core_fifo i_core_fifo (
      .clk_i           ( clk_i            ),
      .rst_ni          ( rst_ni           ),
      .clear_i         ( clear_i          ),
      .req_i           ( req_i[p]         ),
      .req_data_i      ( req_data_i[p]    ),
      .gnt_o           ( gnt_o[p]         ),
      .r_valid_o       ( r_valid_o[p]     ),
      .r_data_o        ( r_data_o[p]      ),
      .r_ready_i       ( r_ready_i[p]     ),
      .mem_req_o       ( arb_req[p]       ),
      .mem_data_o      ( arb_data[p]      ),
      .mem_gnt_i       ( arb_gnt[p]       ),
      .mem_rsp_valid_i ( arb_rsp_valid[p] ),
      .mem_rsp_i       ( arb_rsp[p]       ),
      .flags_o         ( port_flags[p]    )
    );
    assign port_empty[p] = port_flags[p].empty;
    assign port_full[p]  = port_flags[p].full;
  end

  mem_arbiter i_arbiter (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .req_i            ( arb_req        ),
    .req_data_i       ( arb_data       ),
    .gnt_o            ( arb_gnt        ),
    .rsp_valid_o      ( arb_rsp_valid  ),
    .rsp_o            ( arb_rsp        ),
    .bank_req_o       ( bank_req       ),
    .bank_data_o      ( bank_data      ),
    .bank_rsp_valid_i ( bank_rsp_valid ),
    .bank_rsp_i       ( bank_rsp       )
  );

  sram_bank i_bank (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .req_i       ( bank_req       ),
    .req_data_i  ( bank_data      ),
    .rsp_valid_o ( bank_rsp_valid ),
    .rsp_o       ( bank_rsp       )
  );

  assign flags_o.empty = &port_empty;  // whole subsystem idle.
  assign flags_o.full  = |port_full;   // some port is back-pressured.

endmodule

// File: test/tb_checker.sv
// response checker
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_checker (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic [`N_PORTS-1:0]              gnt_i,
  input logic [`N_PORTS-1:0]              r_valid_i,
  input logic [`N_PORTS-1:0]              r_ready_i,
  input mem_pkg::mem_rsp_t [`N_PORTS-1:0] r_data_i,
  input mem_pkg::fifo_flags_t             flags_i
);

  mem_pkg::data_t exp_q0[$];     // expected answers of port 0, oldest first.
  mem_pkg::data_t exp_q1[$];     // same for port 1.
  int             errors = 0;    // all failures so far.
  int             test_errs = 0; // failures in the running test.
  int             test_rsp = 0;  // responses seen in the running test.
  int             total_rsp = 0;
  int             tests = 0;

  function automatic void expect_rsp(input int p, input mem_pkg::data_t d);
    if (p == 0) exp_q0.push_back(d);  // granted request, answer due later.
    else exp_q1.push_back(d);
  endfunction

  function automatic int outstanding();
    return exp_q0.size() + exp_q1.size();
  endfunction

  function automatic int error_count();
    return errors;
  endfunction

  function automatic void report_mismatch(input string sig, input logic [31:0] got,
                                          input logic [31:0] exp);
    $display("** Error at %0t ns: %s got %h, expected %h", $time, sig, got, exp);
    errors++;
    test_errs++;
  endfunction

  function automatic void note_failure(input string msg);
    $display("at %0t ns: %s", $time, msg);  // plain words.
    errors++;
    test_errs++;
  endfunction

  // idle subsystem holds nothing and has room everywhere.
  function automatic void check_idle(input string where);
    if (flags_i.empty !== 1'b1) begin
      report_mismatch({"flags_o.empty ", where}, 32'(flags_i.empty), 32'd1);
    end
    if (flags_i.full !== 1'b0) begin
      report_mismatch({"flags_o.full ", where}, 32'(flags_i.full), 32'd0);
    end
  endfunction

  function automatic void check_rsp(input int p, input mem_pkg::data_t got);
    mem_pkg::data_t exp;
    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
      note_failure($sformatf("port %0d returned a response nobody asked for", p));
      return;
    end
    if (p == 0) exp = exp_q0.pop_front();  // in order per port.
    else exp = exp_q1.pop_front();
    test_rsp++;
    total_rsp++;
    if (got !== exp) report_mismatch($sformatf("r_data_o[%0d].rdata", p), got, exp);
  endfunction

  function automatic void close_test(input string name, input int stalls);
    tests++;
    $display("test %0d %s: %0d responses, %0d gnt wait cycles, %0d errors",
             tests, name, test_rsp, stalls, test_errs);
    test_rsp  = 0;
    test_errs = 0;
  endfunction

  function automatic void print_totals();
    $display("tests %0d, responses %0d, errors %0d", tests, total_rsp, errors);
  endfunction

  // valid and ready are stable at the falling edge, the transfer follows at the rising one.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int p = 0; p < `N_PORTS; p++) begin
        if (r_valid_i[p] && r_ready_i[p]) check_rsp(p, r_data_i[p].rdata);
        if (!gnt_i[p] && flags_i.full !== 1'b1) begin
          report_mismatch($sformatf("flags_o.full with gnt_o[%0d] low", p),
                          32'(flags_i.full), 32'd1);
        end
      end
    end
  end

endmodule

// File: test/tb_top.sv
// memory subsystem testbench
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_top;

  typedef struct packed {
    logic              port;  // issuing port.
    mem_pkg::mem_req_t req;   // request payload.
    mem_pkg::data_t    exp;   // expected rdata.
  } stim_t;

  logic                             clk;
  logic                             rst_n;
  logic                             clear;
  logic [`N_PORTS-1:0]              req;
  mem_pkg::mem_req_t [`N_PORTS-1:0] req_data;
  logic [`N_PORTS-1:0]              gnt;
  logic [`N_PORTS-1:0]              r_valid;
  mem_pkg::mem_rsp_t [`N_PORTS-1:0] r_data;
  logic [`N_PORTS-1:0]              r_ready;
  mem_pkg::fifo_flags_t             flags;
  int                               bp_mode;     // r_ready pattern.
  int                               stalls;      // cycles a port waited on gnt.
  logic [8*24-1:0]                  name_v;      // name of the running test.
  stim_t                            stim_q[$];   // requests of the running test.

  mem_subsys_top i_dut (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .clear_i    ( clear    ),
    .req_i      ( req      ),
    .req_data_i ( req_data ),
    .gnt_o      ( gnt      ),
    .r_valid_o  ( r_valid  ),
    .r_data_o   ( r_data   ),
    .r_ready_i  ( r_ready  ),
    .flags_o    ( flags    )
  );

  tb_checker i_check (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .gnt_i     ( gnt     ),
    .r_valid_i ( r_valid ),
    .r_ready_i ( r_ready ),
    .r_data_i  ( r_data  ),
    .flags_i   ( flags   )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period.
  end

  // one draw per port and cycle.
  initial begin
    void'($urandom(32'h583f));
    forever begin
      @(posedge clk);
      #10;
      for (int p = 0; p < `N_PORTS; p++) begin
        case (bp_mode)
          1:       r_ready[p] = ($urandom & 1) != 0;
          2:       r_ready[p] = ($urandom & 7) == 0;  // long low stretches.
          default: r_ready[p] = 1'b1;
        endcase
      end
    end
  end

  task automatic drive_port(input int p);
    int waited;
    foreach (stim_q[i]) begin
      if (int'(stim_q[i].port) == p) begin
        @(posedge clk);
        #10;
        req[p]      = 1'b1;
        req_data[p] = stim_q[i].req;
        waited      = 0;
        @(negedge clk);  // gnt comes from registered fill level.
        while (!gnt[p] && waited < 200) begin
          waited++;
          stalls++;
          @(negedge clk);
        end
        if (gnt[p]) i_check.expect_rsp(p, stim_q[i].exp);
        else i_check.note_failure($sformatf("port %0d got no gnt within 200 cycles", p));
      end
    end
    @(posedge clk);
    #10;
    req[p] = 1'b0;
  endtask

  task automatic run_test();
    int waited;
    stalls = 0;
    fork
      drive_port(0);
      drive_port(1);
    join
    waited = 0;
    while (i_check.outstanding() != 0 && waited < 500) begin
      waited++;
      @(negedge clk);
    end
    if (i_check.outstanding() != 0) begin
      i_check.note_failure($sformatf("responses of test %0s did not arrive", name_v));
    end
    i_check.close_test($sformatf("%0s", name_v), stalls);
    stim_q.delete();
  endtask

  task automatic expect_empty(input string where);
    @(negedge clk);
    i_check.check_idle(where);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    #10;
    clear = 1'b1;
    @(posedge clk);
    #10;
    clear = 1'b0;
    expect_empty("after clear");
  endtask

  initial begin
    int          fd;
    int          code;
    logic [7:0]  cmd;
    int          port_f;
    int          wen_f;
    int          mode_f;
    int unsigned addr_f;
    int unsigned wdata_f;
    int unsigned be_f;
    int unsigned exp_f;
    logic [8*128-1:0] skip;
    stim_t       s;
    rst_n    = 1'b0;
    clear    = 1'b0;
    req      = '0;
    req_data = '0;
    r_ready  = '1;
    bp_mode  = 0;
    stalls   = 0;
    name_v   = '0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    expect_empty("after reset");
    fd = $fopen("test/stim_input.txt", "r");
    if (fd == 0) begin
      i_check.note_failure("cannot open test/stim_input.txt");
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        case (cmd)
          "#": code = $fgets(skip, fd);  // column notes.
          "T": code = $fscanf(fd, " %s", name_v);
          "B": begin
            code    = $fscanf(fd, " %d", mode_f);
            bp_mode = mode_f;
          end
          "C": pulse_clear();
          "E": run_test();
          "R": begin
            code = $fscanf(fd, " %d %d %h %h %h %h", port_f, wen_f, addr_f, wdata_f,
                           be_f, exp_f);
            s.port      = port_f[0];
            s.req.addr  = mem_pkg::addr_t'(addr_f);
            s.req.wdata = wdata_f;
            s.req.be    = mem_pkg::be_t'(be_f);
            s.req.wen   = wen_f[0];
            s.exp       = exp_f;
            stim_q.push_back(s);
          end
          default: i_check.note_failure($sformatf("unknown command %c in stimulus", cmd));
        endcase
      end
      $fclose(fd);
    end
    bp_mode = 0;
    expect_empty("after final drain");
    i_check.print_totals();
    if (i_check.error_count() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/mem_pkg.sv
logic/stream_fifo.sv
logic/sram_bank.sv
logic/mem_arbiter.sv
logic/core_fifo.sv
logic/mem_subsys_top.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f src.f \
  --Mdir obj_dir -o tb_top_sim
./obj_dir/tb_top_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// File: test/stim_input.txt
# T name starts a test | R port wen addr wdata be rdata_expected (hex) | E issues and drains
# B mode sets r_ready (0 high, 1 random, 2 mostly low) | C pulses clear_i while idle
T write_read
R 0 1 010 cafef00d f 00000000
R 0 0 010 00000000 0 cafef00d
E
T byte_enable
R 0 1 011 11223344 f 00000000
R 0 1 011 aabbccdd 5 00000000
R 0 0 011 00000000 0 11bb33dd
E
B 1
T two_ports
R 0 1 040 a0000001 f 00000000
R 1 1 080 b0000001 f 00000000
R 0 1 041 a0000002 f 00000000
R 1 1 081 b0000002 f 00000000
R 0 0 040 00000000 0 a0000001
R 1 0 080 00000000 0 b0000001
R 0 0 041 00000000 0 a0000002
R 1 0 081 00000000 0 b0000002
E
B 2
T back_pressure
R 0 0 010 00000000 0 cafef00d
R 0 0 011 00000000 0 11bb33dd
R 0 0 040 00000000 0 a0000001
R 0 0 041 00000000 0 a0000002
R 0 0 010 00000000 0 cafef00d
R 0 0 011 00000000 0 11bb33dd
R 0 0 040 00000000 0 a0000001
R 0 0 041 00000000 0 a0000002
R 0 0 010 00000000 0 cafef00d
R 1 0 080 00000000 0 b0000001
R 1 0 081 00000000 0 b0000002
E
B 0
T clear
C
E
T cross_write
R 0 1 200 5a5a5a5a f 00000000
E
T cross_read
R 1 0 200 00000000 0 5a5a5a5a
E
